//--- access_ctrl.sv
`timescale 1ns/1ps

module access_ctrl (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  cpu_cyc,
    input  logic                  cpu_stb,
    input  logic                  cpu_we,
    input  mmu_pkg::access_t      cpu_access,
    input  logic [31:0]           cpu_adr,
    input  logic [31:0]           cpu_dat_w,
    output logic [31:0]           cpu_dat_r,
    output logic                  cpu_ack,
    output logic                  cpu_fault,
    output mmu_pkg::cause_t       cpu_cause,
    input  mmu_pkg::priv_t        priv,
    input  logic                  satp_mode,
    input  logic                  tlb_flush,
    input  logic                  hit_code,
    input  logic                  hit_read,
    input  logic                  hit_write,
    input  mmu_pkg::tlb_entry_t   entry_code,
    input  mmu_pkg::tlb_entry_t   entry_read,
    input  mmu_pkg::tlb_entry_t   entry_write,
    output logic                  fill_code,
    output logic                  fill_read,
    output logic                  fill_write,
    output mmu_pkg::tlb_entry_t   fill_entry,
    output logic                  walk_start,
    input  logic                  walk_done,
    input  mmu_pkg::walk_result_t walk_result,
    mem_bus_if.slave              walk_bus,
    mem_bus_if.master             mem_bus
);

    typedef enum logic [1:0] {
        s_idle,
        s_walk,
        s_data
    } state_t;

    state_t              state;
    logic                req;
    logic                bypass;
    logic                sel_hit;
    logic                fill_ok;
    mmu_pkg::tlb_entry_t sel_entry;
    logic [31:0]         tlb_paddr;
    logic [31:0]         paddr_q;

    // No new request while the ack is out or the TLBs are flushing
    assign req    = cpu_cyc && cpu_stb && !cpu_ack && !tlb_flush;
    assign bypass = (priv == mmu_pkg::priv_m) || !satp_mode;

    always_comb begin
        case (cpu_access)
            mmu_pkg::access_code: begin
                sel_hit   = hit_code;
                sel_entry = entry_code;
            end
            mmu_pkg::access_read: begin
                sel_hit   = hit_read;
                sel_entry = entry_read;
            end
            default: begin
                sel_hit   = hit_write;
                sel_entry = entry_write;
            end
        endcase
    end

    // Megapage keeps a 22-bit offset
    assign tlb_paddr = sel_entry.superpage ?
        {sel_entry.ppn[mmu_pkg::ppn_w-1:mmu_pkg::vpn_w],
         cpu_adr[mmu_pkg::vpn_w+mmu_pkg::page_off_w-1:0]} :
        {sel_entry.ppn, cpu_adr[mmu_pkg::page_off_w-1:0]};

    assign walk_start = (state == s_idle) && req && !bypass && !sel_hit;

    // Fill on a good walk result, the lookup retries from idle
    assign fill_ok          = (state == s_walk) && walk_done && walk_result.ok;
    assign fill_code        = fill_ok && (cpu_access == mmu_pkg::access_code);
    assign fill_read        = fill_ok && (cpu_access == mmu_pkg::access_read);
    assign fill_write       = fill_ok && (cpu_access == mmu_pkg::access_write);
    assign fill_entry.ppn       = walk_result.ppn;
    assign fill_entry.superpage = walk_result.superpage;

    // Memory bus owner, walker during a walk
    always_comb begin
        if (state == s_walk) begin
            mem_bus.cyc   = walk_bus.cyc;
            mem_bus.stb   = walk_bus.stb;
            mem_bus.adr   = walk_bus.adr;
            mem_bus.dat_w = walk_bus.dat_w;
            mem_bus.we    = walk_bus.we;
        end else begin
            mem_bus.cyc   = (state == s_data);
            mem_bus.stb   = (state == s_data);
            mem_bus.adr   = paddr_q;
            mem_bus.dat_w = cpu_dat_w;
            mem_bus.we    = (state == s_data) && cpu_we;
        end
    end

    assign walk_bus.dat_r = mem_bus.dat_r;
    assign walk_bus.ack   = (state == s_walk) && mem_bus.ack;

    always_ff @(posedge CLK) begin
        if (reset) begin
            state     <= s_idle;
            cpu_ack   <= 1'b0;
            cpu_fault <= 1'b0;
        end else begin
            cpu_ack   <= 1'b0;
            cpu_fault <= 1'b0;
            case (state)
                s_idle: begin
                    if (req) begin
                        state <= (bypass || sel_hit) ? s_data : s_walk;
                    end
                end
                s_walk: begin
                    if (walk_done) begin
                        state <= s_idle;
                        if (!walk_result.ok) begin
                            cpu_ack   <= 1'b1;
                            cpu_fault <= 1'b1;
                        end
                    end
                end
                s_data: begin
                    if (mem_bus.ack) begin
                        state   <= s_idle;
                        cpu_ack <= 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == s_idle) begin
            paddr_q <= bypass ? cpu_adr : tlb_paddr;
        end
        if ((state == s_data) && mem_bus.ack) begin
            cpu_dat_r <= mem_bus.dat_r;
        end
        if ((state == s_walk) && walk_done) begin
            cpu_cause <= walk_result.cause;
        end
    end

endmodule

//--- mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;

    logic [mmu_pkg::xlen-1:0] adr;
    logic [mmu_pkg::xlen-1:0] dat_w;
    logic [mmu_pkg::xlen-1:0] dat_r;
    logic                     we;
    logic                     cyc;
    logic                     stb;
    logic                     ack;

    // Wishbone classic, single outstanding cycle
    modport master (
        output adr, dat_w, we, cyc, stb,
        input  dat_r, ack
    );

    modport slave (
        input  adr, dat_w, we, cyc, stb,
        output dat_r, ack
    );

endinterface

//--- mmu.f
mmu_pkg.sv
mem_bus_if.sv
tlb.sv
pte_check.sv
page_walker.sv
access_ctrl.sv
sv32_mmu.sv
tb_memory.sv
mmu_properties.sv
mmu_tb.sv

//--- mmu_pkg.sv
package mmu_pkg;

    // Sv32 field widths
    localparam int xlen       = 32;
    localparam int vpn_w      = 10;
    localparam int ppn_w      = 20;
    localparam int page_off_w = 12;

    // TLB geometry, direct mapped on the low VPN bits
    localparam int tlb_entries = 16;
    localparam int tlb_idx_w   = $clog2(tlb_entries);
    localparam int tlb_tag_w   = 2 * vpn_w - tlb_idx_w;

    typedef enum logic [1:0] {
        access_code  = 2'd0,
        access_read  = 2'd1,
        access_write = 2'd2
    } access_t;

    typedef enum logic [1:0] {
        priv_u = 2'd0,
        priv_s = 2'd1,
        priv_m = 2'd3
    } priv_t;

    // Sv32 PTE, bit 0 is v
    typedef struct packed {
        // Upper PPN bits, ignored with 32-bit physical addresses
        logic [1:0]       ppn_hi;
        logic [ppn_w-1:0] ppn;
        logic [1:0]       rsw;
        logic             d;
        logic             a;
        logic             g;
        logic             u;
        logic             x;
        logic             w;
        logic             r;
        logic             v;
    } pte_t;

    typedef struct packed {
        logic [ppn_w-1:0] ppn;
        logic             superpage;
    } tlb_entry_t;

    typedef enum logic [xlen-1:0] {
        cause_fetch_pf = 32'd12,
        cause_load_pf  = 32'd13,
        cause_store_pf = 32'd15
    } cause_t;

    typedef struct packed {
        logic             ok;
        logic             superpage;
        logic [ppn_w-1:0] ppn;
        cause_t           cause;
    } walk_result_t;

    // Page fault cause for an access kind
    function automatic cause_t access_cause(access_t access);
        case (access)
            access_code: return cause_fetch_pf;
            access_read: return cause_load_pf;
            default:     return cause_store_pf;
        endcase
    endfunction

endpackage

//--- mmu_properties.sv
`timescale 1ns/1ps

module mmu_properties (
    input logic        CLK,
    input logic        reset,
    input logic        cpu_cyc,
    input logic        cpu_ack,
    input logic        cpu_fault,
    input logic        mem_cyc,
    input logic        mem_stb,
    input logic        mem_we,
    input logic        mem_ack,
    input logic [31:0] mem_adr
);

    int fail_count = 0;

    task automatic note_failure(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    // Master holds the cycle until the slave answers
    cyc_held: assert property (@(posedge CLK) disable iff (reset)
        (mem_cyc && !mem_ack) |=> mem_cyc)
        else note_failure("mem_cyc dropped before mem_ack");

    stb_in_cyc: assert property (@(posedge CLK) disable iff (reset)
        mem_stb |-> mem_cyc)
        else note_failure("mem_stb raised without mem_cyc");

    adr_stable: assert property (@(posedge CLK) disable iff (reset)
        (mem_cyc && !mem_ack) |=> ($stable(mem_adr) && $stable(mem_we)))
        else note_failure("mem_adr or mem_we changed while waiting for mem_ack");

    ack_in_cyc: assert property (@(posedge CLK) disable iff (reset)
        cpu_ack |-> cpu_cyc)
        else note_failure("cpu_ack raised outside a processor cycle");

    fault_with_ack: assert property (@(posedge CLK) disable iff (reset)
        cpu_fault |-> cpu_ack)
        else note_failure("cpu_fault raised without cpu_ack");

endmodule

//--- mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

    localparam int ack_timeout = 200;

    // Short names for the table columns
    localparam mmu_pkg::priv_t   u_mode   = mmu_pkg::priv_u;
    localparam mmu_pkg::priv_t   s_mode   = mmu_pkg::priv_s;
    localparam mmu_pkg::priv_t   m_mode   = mmu_pkg::priv_m;
    localparam mmu_pkg::access_t fetch    = mmu_pkg::access_code;
    localparam mmu_pkg::access_t rd       = mmu_pkg::access_read;
    localparam mmu_pkg::access_t wr       = mmu_pkg::access_write;
    localparam mmu_pkg::cause_t  pf_fetch = mmu_pkg::cause_fetch_pf;
    localparam mmu_pkg::cause_t  pf_load  = mmu_pkg::cause_load_pf;
    localparam mmu_pkg::cause_t  pf_store = mmu_pkg::cause_store_pf;

    typedef struct {
        mmu_pkg::priv_t   priv;
        logic             mode;
        logic             sum;
        logic             mxr;
        logic             flush;
        mmu_pkg::access_t access;
        logic [31:0]      vaddr;
        logic             fault;
        mmu_pkg::cause_t  cause;
        // Physical target and its expected word after the row
        logic [31:0]      paddr;
        logic [31:0]      data;
        logic [31:0]      pte_adr;
        mmu_pkg::pte_t    pte_val;
    } row_t;

    row_t rows [$];

    logic             CLK;
    logic             reset;
    logic             cpu_cyc, cpu_stb, cpu_we;
    mmu_pkg::access_t cpu_access;
    logic [31:0]      cpu_adr, cpu_dat_w, cpu_dat_r;
    logic             cpu_ack, cpu_fault;
    mmu_pkg::cause_t  cpu_cause;
    mmu_pkg::priv_t   priv;
    logic             satp_mode;
    logic [19:0]      satp_ppn;
    logic             mstatus_sum, mstatus_mxr;
    logic             tlb_flush;
    logic             mem_cyc, mem_stb, mem_we, mem_ack;
    logic [31:0]      mem_adr, mem_dat_w, mem_dat_r;

    sv32_mmu DUT (.*);

    tb_memory memory (
        .CLK   (CLK),
        .reset (reset),
        .cyc   (mem_cyc),
        .stb   (mem_stb),
        .we    (mem_we),
        .adr   (mem_adr),
        .dat_w (mem_dat_w),
        .dat_r (mem_dat_r),
        .ack   (mem_ack)
    );

    bind sv32_mmu mmu_properties props (
        .CLK       (CLK),
        .reset     (reset),
        .cpu_cyc   (cpu_cyc),
        .cpu_ack   (cpu_ack),
        .cpu_fault (cpu_fault),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_ack   (mem_ack),
        .mem_adr   (mem_adr)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_cause(input mmu_pkg::cause_t actual, input mmu_pkg::cause_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error: cpu_cause is %h, expected %h", actual, expected));
        end
    endtask

    task automatic check_pte(input logic [31:0] adr, input mmu_pkg::pte_t expected);
        mmu_pkg::pte_t actual;
        actual = memory.peek(adr);
        if (actual !== expected) begin
            report_failure($sformatf("Error: pte at %h is %h, expected %h",
                                     adr, actual, expected));
        end
    endtask

    task automatic add_row(input mmu_pkg::priv_t p, input logic mode, input logic sum,
                           input logic mxr, input logic flush, input mmu_pkg::access_t access,
                           input logic [31:0] vaddr, input logic fault,
                           input mmu_pkg::cause_t cause, input logic [31:0] paddr,
                           input logic [31:0] data, input logic [31:0] pte_adr,
                           input logic [31:0] pte_val);
        row_t r;
        r = '{p, mode, sum, mxr, flush, access, vaddr, fault, cause,
              paddr, data, pte_adr, pte_val};
        rows.push_back(r);
    endtask

    // Root table at 0x10000, level-0 table at 0x11000
    task automatic build_page_tables();
        memory.load_word(32'h0001_0004, 32'h0000_4401);
        memory.load_word(32'h0001_0008, 32'h0010_00d7);
        memory.load_word(32'h0001_1000, 32'h0000_8017);
        memory.load_word(32'h0001_1004, 32'h0000_8443);
        memory.load_word(32'h0001_1008, 32'h0000_8859);
        memory.load_word(32'h0001_100c, 32'h0000_8c16);
        memory.load_word(32'h0001_1010, 32'h0000_90d7);
        memory.load_word(32'h0002_1000, 32'h2121_0000);
        memory.load_word(32'h0002_2008, 32'h2222_0008);
        memory.load_word(32'h0002_3000, 32'h3333_0000);
        memory.load_word(32'h0002_4000, 32'h2424_0000);
        memory.load_word(32'h0002_5000, 32'h2525_0000);
    endtask

    task automatic build_table();
        // Bypass in M mode and with translation off
        add_row(m_mode, 1, 0, 0, 0, wr, 32'h0003_0000, 0, pf_store,
                32'h0003_0000, 32'hcafe_0001, 32'h0, 32'h0);
        add_row(m_mode, 1, 0, 0, 0, rd, 32'h0003_0000, 0, pf_load,
                32'h0003_0000, 32'hcafe_0001, 32'h0, 32'h0);
        add_row(u_mode, 0, 0, 0, 0, wr, 32'h0003_0004, 0, pf_store,
                32'h0003_0004, 32'h0bad_f00d, 32'h0, 32'h0);
        add_row(u_mode, 0, 0, 0, 0, rd, 32'h0003_0004, 0, pf_load,
                32'h0003_0004, 32'h0bad_f00d, 32'h0, 32'h0);
        // 4 KiB user page, the store sets A and D
        add_row(u_mode, 1, 0, 0, 0, wr, 32'h0040_0010, 0, pf_store,
                32'h0002_0010, 32'h1234_5678, 32'h0001_1000, 32'h0000_80d7);
        add_row(u_mode, 1, 0, 0, 0, rd, 32'h0040_0010, 0, pf_load,
                32'h0002_0010, 32'h1234_5678, 32'h0001_1000, 32'h0000_80d7);
        // Megapage
        add_row(u_mode, 1, 0, 0, 0, wr, 32'h0081_2344, 0, pf_store,
                32'h0041_2344, 32'h600d_beef, 32'h0001_0008, 32'h0010_00d7);
        add_row(u_mode, 1, 0, 0, 0, rd, 32'h0081_2344, 0, pf_load,
                32'h0041_2344, 32'h600d_beef, 32'h0001_0008, 32'h0010_00d7);
        // Invalid PTE
        add_row(u_mode, 1, 0, 0, 0, wr, 32'h0040_3000, 1, pf_store,
                32'h0002_3000, 32'h3333_0000, 32'h0001_100c, 32'h0000_8c16);
        add_row(u_mode, 1, 0, 0, 0, fetch, 32'h0040_3000, 1, pf_fetch,
                32'h0002_3000, 32'h3333_0000, 32'h0001_100c, 32'h0000_8c16);
        // User page from S mode, without and with SUM
        add_row(s_mode, 1, 0, 0, 1, wr, 32'h0040_0010, 1, pf_store,
                32'h0002_0010, 32'h1234_5678, 32'h0001_1000, 32'h0000_80d7);
        add_row(s_mode, 1, 1, 0, 1, rd, 32'h0040_0010, 0, pf_load,
                32'h0002_0010, 32'h1234_5678, 32'h0001_1000, 32'h0000_80d7);
        // Supervisor read-only page
        add_row(s_mode, 1, 0, 0, 0, wr, 32'h0040_1000, 1, pf_store,
                32'h0002_1000, 32'h2121_0000, 32'h0001_1004, 32'h0000_8443);
        add_row(s_mode, 1, 0, 0, 0, rd, 32'h0040_1000, 0, pf_load,
                32'h0002_1000, 32'h2121_0000, 32'h0001_1004, 32'h0000_8443);
        // Execute-only page, readable only with MXR
        add_row(u_mode, 1, 0, 0, 0, rd, 32'h0040_2008, 1, pf_load,
                32'h0002_2008, 32'h2222_0008, 32'h0001_1008, 32'h0000_8859);
        add_row(u_mode, 1, 0, 1, 0, rd, 32'h0040_2008, 0, pf_load,
                32'h0002_2008, 32'h2222_0008, 32'h0001_1008, 32'h0000_8859);
        add_row(u_mode, 1, 0, 0, 0, fetch, 32'h0040_2008, 0, pf_fetch,
                32'h0002_2008, 32'h2222_0008, 32'h0001_1008, 32'h0000_8859);
        // Remap through M mode, stale TLB entry until the flush
        add_row(u_mode, 1, 0, 0, 0, rd, 32'h0040_4000, 0, pf_load,
                32'h0002_4000, 32'h2424_0000, 32'h0001_1010, 32'h0000_90d7);
        add_row(m_mode, 1, 0, 0, 0, wr, 32'h0001_1010, 0, pf_store,
                32'h0001_1010, 32'h0000_94d7, 32'h0001_1010, 32'h0000_94d7);
        add_row(u_mode, 1, 0, 0, 0, rd, 32'h0040_4000, 0, pf_load,
                32'h0002_4000, 32'h2424_0000, 32'h0001_1010, 32'h0000_94d7);
        add_row(u_mode, 1, 0, 0, 1, rd, 32'h0040_4000, 0, pf_load,
                32'h0002_5000, 32'h2525_0000, 32'h0001_1010, 32'h0000_94d7);
    endtask

    task automatic apply_row(input row_t r);
        int waited;
        waited = 0;
        if (r.flush) begin
            tlb_flush = 1'b1;
            @(posedge CLK);
            #1;
            tlb_flush = 1'b0;
        end
        priv        = r.priv;
        satp_mode   = r.mode;
        mstatus_sum = r.sum;
        mstatus_mxr = r.mxr;
        cpu_access  = r.access;
        cpu_we      = (r.access == wr);
        cpu_adr     = r.vaddr;
        // A faulting store carries data that must not reach memory
        cpu_dat_w   = r.fault ? ~r.data : r.data;
        cpu_cyc     = 1'b1;
        cpu_stb     = 1'b1;
        do begin
            @(posedge CLK);
            #1;
            waited++;
            if (waited > ack_timeout) begin
                report_failure($sformatf("No cpu_ack for address %h within %0d cycles",
                                         r.vaddr, ack_timeout));
            end
        end while (!cpu_ack);
        check_bit("cpu_fault", cpu_fault, r.fault);
        if (r.fault) begin
            check_cause(cpu_cause, r.cause);
        end else if (r.access != wr) begin
            check_word("cpu_dat_r", cpu_dat_r, r.data);
        end
        check_word($sformatf("mem[%h]", r.paddr), memory.peek(r.paddr), r.data);
        if (r.pte_adr != 0) begin
            check_pte(r.pte_adr, r.pte_val);
        end
        // Cycle ends after the ack, then one idle cycle
        @(posedge CLK);
        #1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;
        @(posedge CLK);
        #1;
    endtask

    initial begin
        reset       = 1'b1;
        cpu_cyc     = 1'b0;
        cpu_stb     = 1'b0;
        cpu_we      = 1'b0;
        cpu_access  = rd;
        cpu_adr     = '0;
        cpu_dat_w   = '0;
        priv        = m_mode;
        satp_mode   = 1'b0;
        satp_ppn    = 20'h00010;
        mstatus_sum = 1'b0;
        mstatus_mxr = 1'b0;
        tlb_flush   = 1'b0;
        build_page_tables();
        build_table();
        repeat (3) @(posedge CLK);
        #1;
        reset = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (DUT.props.fail_count != 0) begin
            report_failure($sformatf("Bus protocol assertions failed %0d times",
                                     DUT.props.fail_count));
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

//--- page_walker.sv
`timescale 1ns/1ps

module page_walker (
    input  logic                  CLK,
    input  logic                  reset,
    input  logic                  start,
    input  logic [31:0]           vaddr,
    input  mmu_pkg::access_t      access,
    input  mmu_pkg::priv_t        priv,
    input  logic                  sum,
    input  logic                  mxr,
    input  logic [19:0]           root_ppn,
    output logic                  done,
    output mmu_pkg::walk_result_t result,
    mem_bus_if.master             bus
);

    typedef enum logic [2:0] {
        s_idle,
        s_read1,
        s_judge1,
        s_read0,
        s_judge0,
        s_update
    } state_t;

    state_t        state;
    mmu_pkg::pte_t pte1_q;
    mmu_pkg::pte_t pte0_q;
    mmu_pkg::pte_t leaf_pte;
    mmu_pkg::pte_t wb_pte;

    logic        leaf1, allowed1, update1;
    logic        leaf0, allowed0, update0;
    logic        at_l1;
    logic        judge_ok;
    logic        judge_upd;
    logic        descend;
    logic [31:0] pte1_adr;
    logic [31:0] pte0_adr;

    pte_check check_l1 (
        .pte         (pte1_q),
        .access      (access),
        .priv        (priv),
        .sum         (sum),
        .mxr         (mxr),
        .leaf        (leaf1),
        .allowed     (allowed1),
        .need_update (update1)
    );

    pte_check check_l0 (
        .pte         (pte0_q),
        .access      (access),
        .priv        (priv),
        .sum         (sum),
        .mxr         (mxr),
        .leaf        (leaf0),
        .allowed     (allowed0),
        .need_update (update0)
    );

    // PTE addresses, table page plus VPN times four
    assign pte1_adr = {root_ppn, vaddr[31:32-mmu_pkg::vpn_w], 2'b00};
    assign pte0_adr = {pte1_q.ppn, vaddr[31-mmu_pkg::vpn_w:mmu_pkg::page_off_w], 2'b00};

    assign at_l1     = (state == s_judge1);
    assign judge_ok  = at_l1 ? (leaf1 && allowed1) : (leaf0 && allowed0);
    assign judge_upd = at_l1 ? update1 : update0;
    // Valid pointer at level 1 leads to the next table
    assign descend   = at_l1 && pte1_q.v && !leaf1;

    // Write-back copy of the leaf with A, and D on stores
    assign leaf_pte = result.superpage ? pte1_q : pte0_q;

    always_comb begin
        wb_pte   = leaf_pte;
        wb_pte.a = 1'b1;
        if (access == mmu_pkg::access_write) begin
            wb_pte.d = 1'b1;
        end
    end

    assign bus.cyc   = (state == s_read1) || (state == s_read0) || (state == s_update);
    assign bus.stb   = bus.cyc;
    assign bus.we    = (state == s_update);
    assign bus.dat_w = wb_pte;

    always_comb begin
        case (state)
            s_read0:  bus.adr = pte0_adr;
            s_update: bus.adr = result.superpage ? pte1_adr : pte0_adr;
            default:  bus.adr = pte1_adr;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= s_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                s_idle: begin
                    if (start) begin
                        state <= s_read1;
                    end
                end
                s_read1: begin
                    if (bus.ack) begin
                        state <= s_judge1;
                    end
                end
                s_read0: begin
                    if (bus.ack) begin
                        state <= s_judge0;
                    end
                end
                s_judge1, s_judge0: begin
                    if (descend) begin
                        state <= s_read0;
                    end else if (judge_ok && judge_upd) begin
                        state <= s_update;
                    end else begin
                        state <= s_idle;
                        done  <= 1'b1;
                    end
                end
                s_update: begin
                    if (bus.ack) begin
                        state <= s_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if ((state == s_read1) && bus.ack) begin
            pte1_q <= bus.dat_r;
        end
        if ((state == s_read0) && bus.ack) begin
            pte0_q <= bus.dat_r;
        end
        if ((state == s_judge1) || (state == s_judge0)) begin
            result.ok        <= judge_ok;
            result.superpage <= at_l1;
            result.ppn       <= at_l1 ? pte1_q.ppn : pte0_q.ppn;
            result.cause     <= mmu_pkg::access_cause(access);
        end
    end

endmodule

//--- pte_check.sv
`timescale 1ns/1ps

module pte_check (
    input  mmu_pkg::pte_t    pte,
    input  mmu_pkg::access_t access,
    input  mmu_pkg::priv_t   priv,
    input  logic             sum,
    input  logic             mxr,
    output logic             leaf,
    output logic             allowed,
    output logic             need_update
);

    logic perm;
    logic reserved;
    logic user_fault;

    // Permission needed by the access kind
    always_comb begin
        case (access)
            mmu_pkg::access_code: perm = pte.x;
            mmu_pkg::access_read: perm = pte.r || (mxr && pte.x);
            default:              perm = pte.w;
        endcase
    end

    // Writable without readable is a reserved encoding
    assign reserved = pte.w && !pte.r;

    assign user_fault = ((priv == mmu_pkg::priv_u) && !pte.u) ||
                        ((priv == mmu_pkg::priv_s) && pte.u && !sum);

    assign leaf    = pte.r || pte.w || pte.x;
    assign allowed = pte.v && !reserved && perm && !user_fault;

    // A must be set on every access, D on writes
    assign need_update = !pte.a || ((access == mmu_pkg::access_write) && !pte.d);

endmodule

//--- sv32_mmu.sv
`timescale 1ns/1ps

module sv32_mmu (
    input  logic             CLK,
    input  logic             reset,
    input  logic             cpu_cyc,
    input  logic             cpu_stb,
    input  logic             cpu_we,
    input  mmu_pkg::access_t cpu_access,
    input  logic [31:0]      cpu_adr,
    input  logic [31:0]      cpu_dat_w,
    output logic [31:0]      cpu_dat_r,
    output logic             cpu_ack,
    output logic             cpu_fault,
    output mmu_pkg::cause_t  cpu_cause,
    input  mmu_pkg::priv_t   priv,
    input  logic             satp_mode,
    input  logic [19:0]      satp_ppn,
    input  logic             mstatus_sum,
    input  logic             mstatus_mxr,
    input  logic             tlb_flush,
    output logic             mem_cyc,
    output logic             mem_stb,
    output logic             mem_we,
    output logic [31:0]      mem_adr,
    output logic [31:0]      mem_dat_w,
    input  logic [31:0]      mem_dat_r,
    input  logic             mem_ack
);

    mem_bus_if walk_bus ();
    mem_bus_if mem_bus ();

    logic                  hit_code, hit_read, hit_write;
    logic                  fill_code, fill_read, fill_write;
    mmu_pkg::tlb_entry_t   entry_code, entry_read, entry_write;
    mmu_pkg::tlb_entry_t   fill_entry;
    logic                  walk_start;
    logic                  walk_done;
    mmu_pkg::walk_result_t walk_result;

    tlb tlb_code (
        .CLK        (CLK),
        .reset      (reset),
        .flush      (tlb_flush),
        .fill       (fill_code),
        .fill_vpn   (cpu_adr[31:12]),
        .fill_entry (fill_entry),
        .lookup_vpn (cpu_adr[31:12]),
        .hit        (hit_code),
        .entry      (entry_code)
    );

    tlb tlb_read (
        .CLK        (CLK),
        .reset      (reset),
        .flush      (tlb_flush),
        .fill       (fill_read),
        .fill_vpn   (cpu_adr[31:12]),
        .fill_entry (fill_entry),
        .lookup_vpn (cpu_adr[31:12]),
        .hit        (hit_read),
        .entry      (entry_read)
    );

    tlb tlb_write (
        .CLK        (CLK),
        .reset      (reset),
        .flush      (tlb_flush),
        .fill       (fill_write),
        .fill_vpn   (cpu_adr[31:12]),
        .fill_entry (fill_entry),
        .lookup_vpn (cpu_adr[31:12]),
        .hit        (hit_write),
        .entry      (entry_write)
    );

    page_walker walker (
        .CLK      (CLK),
        .reset    (reset),
        .start    (walk_start),
        .vaddr    (cpu_adr),
        .access   (cpu_access),
        .priv     (priv),
        .sum      (mstatus_sum),
        .mxr      (mstatus_mxr),
        .root_ppn (satp_ppn),
        .done     (walk_done),
        .result   (walk_result),
        .bus      (walk_bus.master)
    );

    access_ctrl ctrl (
        .CLK         (CLK),
        .reset       (reset),
        .cpu_cyc     (cpu_cyc),
        .cpu_stb     (cpu_stb),
        .cpu_we      (cpu_we),
        .cpu_access  (cpu_access),
        .cpu_adr     (cpu_adr),
        .cpu_dat_w   (cpu_dat_w),
        .cpu_dat_r   (cpu_dat_r),
        .cpu_ack     (cpu_ack),
        .cpu_fault   (cpu_fault),
        .cpu_cause   (cpu_cause),
        .priv        (priv),
        .satp_mode   (satp_mode),
        .tlb_flush   (tlb_flush),
        .hit_code    (hit_code),
        .hit_read    (hit_read),
        .hit_write   (hit_write),
        .entry_code  (entry_code),
        .entry_read  (entry_read),
        .entry_write (entry_write),
        .fill_code   (fill_code),
        .fill_read   (fill_read),
        .fill_write  (fill_write),
        .fill_entry  (fill_entry),
        .walk_start  (walk_start),
        .walk_done   (walk_done),
        .walk_result (walk_result),
        .walk_bus    (walk_bus.slave),
        .mem_bus     (mem_bus.master)
    );

    // Memory side of the bus leaves as plain ports
    assign mem_cyc       = mem_bus.cyc;
    assign mem_stb       = mem_bus.stb;
    assign mem_we        = mem_bus.we;
    assign mem_adr       = mem_bus.adr;
    assign mem_dat_w     = mem_bus.dat_w;
    assign mem_bus.dat_r = mem_dat_r;
    assign mem_bus.ack   = mem_ack;

endmodule

//--- tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
    input  logic        CLK,
    input  logic        reset,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [31:0] adr,
    input  logic [31:0] dat_w,
    output logic [31:0] dat_r,
    output logic        ack
);

    // Sparse word storage keyed by word address
    logic [31:0] words [logic [29:0]];
    integer      seed = 32'h59e;
    int          delay;
    logic        busy;

    // Unwritten words return a pattern of their own address
    function automatic logic [31:0] peek(input logic [31:0] a);
        if (words.exists(a[31:2])) begin
            return words[a[31:2]];
        end
        return {a[31:2], 2'b00} ^ 32'h5a5a_c3c3;
    endfunction

    task automatic load_word(input logic [31:0] a, input logic [31:0] data);
        words[a[31:2]] = data;
    endtask

    // One ack per cycle, after 0 to 3 wait states
    always @(posedge CLK) begin
        if (reset) begin
            ack   <= 1'b0;
            busy  <= 1'b0;
            delay <= 0;
            dat_r <= '0;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (!busy) begin
                    busy  <= 1'b1;
                    delay <= {$random(seed)} % 4;
                end else if (delay != 0) begin
                    delay <= delay - 1;
                end else begin
                    busy <= 1'b0;
                    ack  <= 1'b1;
                    if (we) begin
                        words[adr[31:2]] = dat_w;
                    end else begin
                        dat_r <= peek(adr);
                    end
                end
            end
        end
    end

endmodule

//--- tlb.sv
`timescale 1ns/1ps

module tlb (
    input  logic                CLK,
    input  logic                reset,
    input  logic                flush,
    input  logic                fill,
    input  logic [19:0]         fill_vpn,
    input  mmu_pkg::tlb_entry_t fill_entry,
    input  logic [19:0]         lookup_vpn,
    output logic                hit,
    output mmu_pkg::tlb_entry_t entry
);

    logic [mmu_pkg::tlb_entries-1:0] valid;
    logic [mmu_pkg::tlb_tag_w-1:0]   tag_mem   [mmu_pkg::tlb_entries];
    mmu_pkg::tlb_entry_t             entry_mem [mmu_pkg::tlb_entries];

    logic [mmu_pkg::tlb_idx_w-1:0]   lookup_idx;
    logic [mmu_pkg::tlb_tag_w-1:0]   lookup_tag;
    logic [mmu_pkg::tlb_idx_w-1:0]   fill_idx;
    logic [mmu_pkg::tlb_tag_w-1:0]   fill_tag;

    assign lookup_idx = lookup_vpn[mmu_pkg::tlb_idx_w-1:0];
    assign lookup_tag = lookup_vpn[19:mmu_pkg::tlb_idx_w];
    assign fill_idx   = fill_vpn[mmu_pkg::tlb_idx_w-1:0];
    assign fill_tag   = fill_vpn[19:mmu_pkg::tlb_idx_w];

    // Combinational lookup
    assign hit   = valid[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign entry = entry_mem[lookup_idx];

    always_ff @(posedge CLK) begin
        if (reset || flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (fill) begin
            tag_mem[fill_idx]   <= fill_tag;
            entry_mem[fill_idx] <= fill_entry;
        end
    end

endmodule
